/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_mask_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic {
        lsu_idle,
        lsu_wait
    } lsu_state_t;

    // major opcodes kept by this core
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // load and store widths
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    // alu funct3 codes where bit 30 picks sub and sra
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_shr     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam word_t RESET_PC_DEFAULT = 32'h1eceb000;

endpackage

`default_nettype wire

/* design/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  rv_pkg::word_t     inst,
    output rv_pkg::reg_addr_t rs1_s,
    output rv_pkg::reg_addr_t rs2_s,
    output rv_pkg::reg_addr_t rd_s,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_t   alu_op,
    output logic              use_imm,
    output logic              use_pc,
    output logic              is_load,
    output logic              is_store,
    output logic              regf_we,
    output logic [2:0]        funct3
);

    logic [6:0] opcode;

    // alt is inst[30] and sub only exists in the register form
    function automatic rv_pkg::alu_op_t alu_map(
        input logic [2:0] f3,
        input logic       alt,
        input logic       reg_form
    );
        case (f3)
            rv_pkg::f3_add_sub: return (alt && reg_form) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:     return rv_pkg::alu_sll;
            rv_pkg::f3_slt:     return rv_pkg::alu_slt;
            rv_pkg::f3_sltu:    return rv_pkg::alu_sltu;
            rv_pkg::f3_xor:     return rv_pkg::alu_xor;
            rv_pkg::f3_shr:     return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:      return rv_pkg::alu_or;
            default:            return rv_pkg::alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        // anything not listed decodes as a bubble
        rs1_s    = '0;
        rs2_s    = '0;
        rd_s     = '0;
        imm      = '0;
        alu_op   = rv_pkg::alu_add;
        use_imm  = 1'b0;
        use_pc   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        regf_we  = 1'b0;
        case (opcode)
            rv_pkg::op_reg: begin
                rs1_s   = inst[19:15];
                rs2_s   = inst[24:20];
                rd_s    = inst[11:7];
                alu_op  = alu_map(funct3, inst[30], 1'b1);
                regf_we = 1'b1;
            end
            rv_pkg::op_imm: begin
                rs1_s   = inst[19:15];
                rd_s    = inst[11:7];
                imm     = {{20{inst[31]}}, inst[31:20]};
                alu_op  = alu_map(funct3, inst[30], 1'b0);
                use_imm = 1'b1;
                regf_we = 1'b1;
            end
            rv_pkg::op_lui, rv_pkg::op_auipc: begin
                // lui adds to x0 and auipc adds to its own pc
                rd_s    = inst[11:7];
                imm     = {inst[31:12], 12'b0};
                use_imm = 1'b1;
                use_pc  = (opcode == rv_pkg::op_auipc);
                regf_we = 1'b1;
            end
            rv_pkg::op_load: begin
                rs1_s   = inst[19:15];
                rd_s    = inst[11:7];
                imm     = {{20{inst[31]}}, inst[31:20]};
                use_imm = 1'b1;
                is_load = 1'b1;
                regf_we = 1'b1;
            end
            rv_pkg::op_store: begin
                rs1_s    = inst[19:15];
                rs2_s    = inst[24:20];
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  logic              regf_we,
    input  rv_pkg::reg_addr_t rd_s,
    input  rv_pkg::word_t     rd_v,
    input  rv_pkg::reg_addr_t rs1_s,
    input  rv_pkg::reg_addr_t rs2_s,
    output rv_pkg::word_t     rs1_v,
    output rv_pkg::word_t     rs2_v
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regf_we && (rd_s != '0)) begin
            regs[rd_s] <= rd_v;
        end
    end

    // write-through so decode sees the writeback of this cycle
    always_comb begin
        if (rs1_s == '0) begin
            rs1_v = '0;
        end else if (regf_we && (rs1_s == rd_s)) begin
            rs1_v = rd_v;
        end else begin
            rs1_v = regs[rs1_s];
        end
        if (rs2_s == '0) begin
            rs2_v = '0;
        end else if (regf_we && (rs2_s == rd_s)) begin
            rs2_v = rd_v;
        end else begin
            rs2_v = regs[rs2_s];
        end
    end

endmodule

`default_nettype wire

/* design/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  rv_pkg::word_t      pc,
    input  rv_pkg::word_t      rs1_v,
    input  rv_pkg::word_t      rs2_v,
    input  rv_pkg::word_t      imm,
    input  rv_pkg::reg_addr_t  rs1_s,
    input  rv_pkg::reg_addr_t  rs2_s,
    input  rv_pkg::alu_op_t    alu_op,
    input  logic               use_imm,
    input  logic               use_pc,
    input  logic               is_store,
    input  logic [2:0]         funct3,
    input  rv_pkg::reg_addr_t  ex_rd_s,
    input  rv_pkg::word_t      ex_rd_v,
    input  logic               ex_we,
    input  rv_pkg::reg_addr_t  wb_rd_s,
    input  rv_pkg::word_t      wb_rd_v,
    input  logic               wb_we,
    output rv_pkg::word_t      alu_out,
    output rv_pkg::word_t      store_data,
    output rv_pkg::byte_mask_t store_mask,
    output rv_pkg::word_t      rs2_fwd
);

    rv_pkg::word_t rs1_fwd;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic          ex_ok;
    logic          wb_ok;
    logic [4:0]    shamt;
    logic [1:0]    lane;

    // a write to x0 is never forwarded
    assign ex_ok = ex_we && (ex_rd_s != '0);
    assign wb_ok = wb_we && (wb_rd_s != '0);

    // newest result wins
    always_comb begin
        if (ex_ok && (ex_rd_s == rs1_s)) begin
            rs1_fwd = ex_rd_v;
        end else if (wb_ok && (wb_rd_s == rs1_s)) begin
            rs1_fwd = wb_rd_v;
        end else begin
            rs1_fwd = rs1_v;
        end
        if (ex_ok && (ex_rd_s == rs2_s)) begin
            rs2_fwd = ex_rd_v;
        end else if (wb_ok && (wb_rd_s == rs2_s)) begin
            rs2_fwd = wb_rd_v;
        end else begin
            rs2_fwd = rs2_v;
        end
    end

    assign op_a  = use_pc ? pc : rs1_fwd;
    assign op_b  = use_imm ? imm : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            rv_pkg::alu_sub:  alu_out = op_a - op_b;
            rv_pkg::alu_sll:  alu_out = op_a << shamt;
            rv_pkg::alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu: alu_out = {31'b0, op_a < op_b};
            rv_pkg::alu_xor:  alu_out = op_a ^ op_b;
            rv_pkg::alu_srl:  alu_out = op_a >> shamt;
            rv_pkg::alu_sra:  alu_out = $signed(op_a) >>> shamt;
            rv_pkg::alu_or:   alu_out = op_a | op_b;
            rv_pkg::alu_and:  alu_out = op_a & op_b;
            default:          alu_out = op_a + op_b;
        endcase
    end

    // effective address low bits pick the byte lane
    assign lane = alu_out[1:0];

    always_comb begin
        store_data = rs2_fwd;
        store_mask = '0;
        if (is_store) begin
            case (funct3)
                rv_pkg::f3_byte: begin
                    store_mask = 4'b0001 << lane;
                    store_data = rs2_fwd << {lane, 3'b000};
                end
                rv_pkg::f3_half: begin
                    store_mask = 4'b0011 << {lane[1], 1'b0};
                    store_data = rs2_fwd << {lane[1], 4'b0000};
                end
                rv_pkg::f3_word: store_mask = 4'b1111;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/rv_load_store.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_load_store (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::word_t      addr,
    input  logic               is_load,
    input  logic               is_store,
    input  logic [2:0]         funct3,
    input  rv_pkg::word_t      store_data,
    input  rv_pkg::byte_mask_t store_mask,
    input  rv_pkg::word_t      dmem_rdata,
    input  logic               dmem_resp,
    output rv_pkg::word_t      dmem_addr,
    output rv_pkg::byte_mask_t dmem_rmask,
    output rv_pkg::byte_mask_t dmem_wmask,
    output rv_pkg::word_t      dmem_wdata,
    output logic               mem_busy,
    output rv_pkg::word_t      load_data
);

    rv_pkg::lsu_state_t state;
    rv_pkg::lsu_state_t state_next;
    logic               mem_op;
    logic               done;
    logic [1:0]         lane;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;

    assign mem_op = is_load || is_store;

    // a response only counts once the request has been seen waiting
    assign done     = (state == rv_pkg::lsu_wait) && dmem_resp;
    assign mem_busy = mem_op && !done;

    // request comes straight from EX/MEM, which holds while busy
    assign dmem_addr  = {addr[31:2], 2'b00};
    assign dmem_rmask = is_load ? 4'b1111 : 4'b0000;
    assign dmem_wmask = is_store ? store_mask : 4'b0000;
    assign dmem_wdata = store_data;

    always_comb begin
        state_next = state;
        case (state)
            rv_pkg::lsu_idle: begin
                if (mem_op) begin
                    state_next = rv_pkg::lsu_wait;
                end
            end
            rv_pkg::lsu_wait: begin
                if (dmem_resp) begin
                    state_next = rv_pkg::lsu_idle;
                end
            end
            default: state_next = rv_pkg::lsu_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rv_pkg::lsu_idle;
        end else begin
            state <= state_next;
        end
    end

    // pick the lane, then extend
    assign lane    = addr[1:0];
    assign ld_byte = dmem_rdata[{lane, 3'b000} +: 8];
    assign ld_half = dmem_rdata[{lane[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3)
            rv_pkg::f3_byte:   load_data = {{24{ld_byte[7]}}, ld_byte};
            rv_pkg::f3_byte_u: load_data = {24'b0, ld_byte};
            rv_pkg::f3_half:   load_data = {{16{ld_half[15]}}, ld_half};
            rv_pkg::f3_half_u: load_data = {16'b0, ld_half};
            default:           load_data = dmem_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    output rv_pkg::word_t      imem_addr,
    output rv_pkg::byte_mask_t imem_rmask,
    input  rv_pkg::word_t      imem_rdata,
    input  logic               imem_resp,
    output rv_pkg::word_t      dmem_addr,
    output rv_pkg::byte_mask_t dmem_rmask,
    output rv_pkg::byte_mask_t dmem_wmask,
    output rv_pkg::word_t      dmem_wdata,
    input  rv_pkg::word_t      dmem_rdata,
    input  logic               dmem_resp
);

    rv_pkg::word_t      pc;
    rv_pkg::word_t      pc_next;
    logic               fetch_en;
    logic               fetch_go;
    logic               load_use;
    logic               mem_busy;
    logic               wb_rs1_hit;
    logic               wb_rs2_hit;

    // IF/ID
    rv_pkg::word_t      ifid_inst;
    rv_pkg::word_t      ifid_pc;

    // decode and register file outputs
    rv_pkg::reg_addr_t  dec_rs1_s;
    rv_pkg::reg_addr_t  dec_rs2_s;
    rv_pkg::reg_addr_t  dec_rd_s;
    rv_pkg::word_t      dec_imm;
    rv_pkg::alu_op_t    dec_alu_op;
    logic               dec_use_imm;
    logic               dec_use_pc;
    logic               dec_is_load;
    logic               dec_is_store;
    logic               dec_regf_we;
    logic [2:0]         dec_funct3;
    rv_pkg::word_t      rf_rs1_v;
    rv_pkg::word_t      rf_rs2_v;

    // ID/EX
    rv_pkg::word_t      idex_pc;
    rv_pkg::word_t      idex_rs1_v;
    rv_pkg::word_t      idex_rs2_v;
    rv_pkg::word_t      idex_imm;
    rv_pkg::reg_addr_t  idex_rs1_s;
    rv_pkg::reg_addr_t  idex_rs2_s;
    rv_pkg::reg_addr_t  idex_rd_s;
    rv_pkg::alu_op_t    idex_alu_op;
    logic               idex_use_imm;
    logic               idex_use_pc;
    logic               idex_is_load;
    logic               idex_is_store;
    logic               idex_regf_we;
    logic [2:0]         idex_funct3;

    // execute outputs
    rv_pkg::word_t      ex_alu_out;
    rv_pkg::word_t      ex_store_data;
    rv_pkg::byte_mask_t ex_store_mask;

    // EX/MEM
    rv_pkg::word_t      exmem_alu;
    rv_pkg::word_t      exmem_store_data;
    rv_pkg::byte_mask_t exmem_store_mask;
    rv_pkg::reg_addr_t  exmem_rd_s;
    logic               exmem_is_load;
    logic               exmem_is_store;
    logic               exmem_regf_we;
    logic [2:0]         exmem_funct3;
    rv_pkg::word_t      load_data;

    // MEM/WB
    rv_pkg::word_t      memwb_rd_v;
    rv_pkg::reg_addr_t  memwb_rd_s;
    logic               memwb_regf_we;

    // load in EX/MEM feeding the instruction in EX
    assign load_use = exmem_is_load && (exmem_rd_s != '0) &&
                      ((exmem_rd_s == idex_rs1_s) || (exmem_rd_s == idex_rs2_s));

    // fetch_en keeps the pc at its reset value for one cycle after reset
    assign fetch_go   = fetch_en && imem_resp && !mem_busy && !load_use;
    assign pc_next    = fetch_go ? pc + 32'd4 : pc;
    assign imem_addr  = pc_next;
    assign imem_rmask = 4'b1111;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            fetch_en <= 1'b0;
        end else begin
            pc       <= pc_next;
            fetch_en <= 1'b1;
        end
    end

    // a stalled instruction in EX would lose a result that retires meanwhile
    assign wb_rs1_hit = memwb_regf_we && (memwb_rd_s != '0) && (memwb_rd_s == idex_rs1_s);
    assign wb_rs2_hit = memwb_regf_we && (memwb_rd_s != '0) && (memwb_rd_s == idex_rs2_s);

    // bubbles have every control bit low
    always_ff @(posedge clk) begin
        if (rst) begin
            ifid_inst      <= '0;
            idex_rs1_s     <= '0;
            idex_rs2_s     <= '0;
            idex_rd_s      <= '0;
            idex_is_load   <= 1'b0;
            idex_is_store  <= 1'b0;
            idex_regf_we   <= 1'b0;
            exmem_rd_s     <= '0;
            exmem_is_load  <= 1'b0;
            exmem_is_store <= 1'b0;
            exmem_regf_we  <= 1'b0;
            memwb_rd_s     <= '0;
            memwb_regf_we  <= 1'b0;
        end else if (!mem_busy) begin
            memwb_rd_s    <= exmem_rd_s;
            memwb_regf_we <= exmem_regf_we;
            if (load_use) begin
                exmem_rd_s     <= '0;
                exmem_is_load  <= 1'b0;
                exmem_is_store <= 1'b0;
                exmem_regf_we  <= 1'b0;
            end else begin
                ifid_inst      <= fetch_go ? imem_rdata : '0;
                idex_rs1_s     <= dec_rs1_s;
                idex_rs2_s     <= dec_rs2_s;
                idex_rd_s      <= dec_rd_s;
                idex_is_load   <= dec_is_load;
                idex_is_store  <= dec_is_store;
                idex_regf_we   <= dec_regf_we;
                exmem_rd_s     <= idex_rd_s;
                exmem_is_load  <= idex_is_load;
                exmem_is_store <= idex_is_store;
                exmem_regf_we  <= idex_regf_we;
            end
        end
    end

    // payload follows the same enables
    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            memwb_rd_v <= exmem_is_load ? load_data : exmem_alu;
            if (load_use) begin
                if (wb_rs1_hit) begin
                    idex_rs1_v <= memwb_rd_v;
                end
                if (wb_rs2_hit) begin
                    idex_rs2_v <= memwb_rd_v;
                end
            end else begin
                ifid_pc          <= pc;
                idex_pc          <= ifid_pc;
                idex_rs1_v       <= rf_rs1_v;
                idex_rs2_v       <= rf_rs2_v;
                idex_imm         <= dec_imm;
                idex_alu_op      <= dec_alu_op;
                idex_use_imm     <= dec_use_imm;
                idex_use_pc      <= dec_use_pc;
                idex_funct3      <= dec_funct3;
                exmem_alu        <= ex_alu_out;
                exmem_store_data <= ex_store_data;
                exmem_store_mask <= ex_store_mask;
                exmem_funct3     <= idex_funct3;
            end
        end
    end

    rv_decode u_rv_decode (
        .inst     (ifid_inst),
        .rs1_s    (dec_rs1_s),
        .rs2_s    (dec_rs2_s),
        .rd_s     (dec_rd_s),
        .imm      (dec_imm),
        .alu_op   (dec_alu_op),
        .use_imm  (dec_use_imm),
        .use_pc   (dec_use_pc),
        .is_load  (dec_is_load),
        .is_store (dec_is_store),
        .regf_we  (dec_regf_we),
        .funct3   (dec_funct3)
    );

    rv_regfile u_rv_regfile (
        .clk     (clk),
        .rst     (rst),
        .regf_we (memwb_regf_we),
        .rd_s    (memwb_rd_s),
        .rd_v    (memwb_rd_v),
        .rs1_s   (dec_rs1_s),
        .rs2_s   (dec_rs2_s),
        .rs1_v   (rf_rs1_v),
        .rs2_v   (rf_rs2_v)
    );

    rv_execute u_rv_execute (
        .pc         (idex_pc),
        .rs1_v      (idex_rs1_v),
        .rs2_v      (idex_rs2_v),
        .imm        (idex_imm),
        .rs1_s      (idex_rs1_s),
        .rs2_s      (idex_rs2_s),
        .alu_op     (idex_alu_op),
        .use_imm    (idex_use_imm),
        .use_pc     (idex_use_pc),
        .is_store   (idex_is_store),
        .funct3     (idex_funct3),
        .ex_rd_s    (exmem_rd_s),
        .ex_rd_v    (exmem_alu),
        .ex_we      (exmem_regf_we),
        .wb_rd_s    (memwb_rd_s),
        .wb_rd_v    (memwb_rd_v),
        .wb_we      (memwb_regf_we),
        .alu_out    (ex_alu_out),
        .store_data (ex_store_data),
        .store_mask (ex_store_mask),
        .rs2_fwd    ()
    );

    rv_load_store u_rv_load_store (
        .clk        (clk),
        .rst        (rst),
        .addr       (exmem_alu),
        .is_load    (exmem_is_load),
        .is_store   (exmem_is_store),
        .funct3     (exmem_funct3),
        .store_data (exmem_store_data),
        .store_mask (exmem_store_mask),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .mem_busy   (mem_busy),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam logic [31:0] NOP      = 32'h00000013;
    localparam logic [31:0] START_PC = 32'h1eceb000;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;

    logic [31:0] prog [0:127];
    int          prog_len;
    logic [31:0] fetch_addr;
    logic [31:0] dmem [logic [31:0]];
    int          wait_left;
    logic        in_flight;

    // expected stores in program order
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_mask [$];
    logic [31:0] exp_data [$];
    int          store_idx;

    // request held from the previous cycle
    logic        req_open;
    logic [31:0] held_addr;
    logic [3:0]  held_rmask;
    logic [3:0]  held_wmask;
    logic [31:0] held_wdata;
    logic        prev_rst;

    int          store_errors;
    int          handshake_errors;
    int          reset_errors;
    int          fetch_errors;
    int          timeout_errors;

    rv_core u_rv_core (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::op_reg};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    // unwritten words depend on the full address
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (dmem.exists(a)) begin
            return dmem[a];
        end
        return {a[15:0], a[31:16]} ^ 32'h3c5a96e1;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_store(input logic [31:0] a, input logic [3:0] m, input logic [31:0] d);
        exp_addr.push_back(a);
        exp_mask.push_back(m);
        exp_data.push_back(d);
    endtask

    // load from the known word at base+40 and store the result back as a word
    task automatic load_then_store(input logic [2:0] f3, input int off, input int dst,
                                   input logic [31:0] value);
        emit(i_type(off, 10, f3, 17, rv_pkg::op_load));
        emit(s_type(dst, 17, 10, 3'b010));
        expect_store(32'h100 + 32'(dst), 4'b1111, value);
    endtask

    task automatic build_program();
        logic [31:0] auipc_pc;
        for (int i = 0; i < 128; i++) begin
            prog[i] = NOP;
        end
        prog_len = 0;
        // back-to-back alu chain
        emit(i_type(256, 0, 3'b000, 10, rv_pkg::op_imm));
        emit(i_type(5, 0, 3'b000, 1, rv_pkg::op_imm));
        emit(r_type(7'h00, 1, 1, 3'b000, 2));
        emit(r_type(7'h20, 1, 2, 3'b000, 3));
        emit(r_type(7'h00, 2, 3, 3'b100, 4));
        emit(r_type(7'h00, 4, 3, 3'b010, 5));
        emit(i_type(-1, 0, 3'b000, 6, rv_pkg::op_imm));
        emit(r_type(7'h00, 6, 5, 3'b011, 7));
        emit(i_type(4, 4, 3'b001, 8, rv_pkg::op_imm));
        emit(i_type(28, 6, 3'b101, 9, rv_pkg::op_imm));
        emit(i_type(32'h404, 6, 3'b101, 11, rv_pkg::op_imm));
        emit(r_type(7'h00, 7, 9, 3'b001, 12));
        emit(s_type(0, 2, 10, 3'b010));
        emit(s_type(4, 3, 10, 3'b010));
        emit(s_type(8, 4, 10, 3'b010));
        emit(s_type(12, 5, 10, 3'b010));
        emit(s_type(16, 7, 10, 3'b010));
        emit(s_type(20, 8, 10, 3'b010));
        emit(s_type(24, 9, 10, 3'b010));
        emit(s_type(28, 11, 10, 3'b010));
        emit(s_type(32, 12, 10, 3'b010));
        expect_store(32'h100, 4'b1111, 32'h0000000a);
        expect_store(32'h104, 4'b1111, 32'h00000005);
        expect_store(32'h108, 4'b1111, 32'h0000000f);
        expect_store(32'h10c, 4'b1111, 32'h00000001);
        expect_store(32'h110, 4'b1111, 32'h00000001);
        expect_store(32'h114, 4'b1111, 32'h000000f0);
        expect_store(32'h118, 4'b1111, 32'h0000000f);
        expect_store(32'h11c, 4'b1111, 32'hffffffff);
        expect_store(32'h120, 4'b1111, 32'h0000001e);
        // load-use
        emit(i_type(0, 10, 3'b010, 14, rv_pkg::op_load));
        emit(r_type(7'h00, 1, 14, 3'b000, 15));
        emit(s_type(36, 15, 10, 3'b010));
        expect_store(32'h124, 4'b1111, 32'h0000000f);
        // known word 8765f0a1 at 0x128
        emit(u_type(32'h8765f, 16, rv_pkg::op_lui));
        emit(i_type(32'h0a1, 16, 3'b000, 16, rv_pkg::op_imm));
        emit(s_type(40, 16, 10, 3'b010));
        expect_store(32'h128, 4'b1111, 32'h8765f0a1);
        load_then_store(3'b000, 40, 44, 32'hffffffa1);
        load_then_store(3'b100, 41, 48, 32'h000000f0);
        load_then_store(3'b000, 42, 52, 32'h00000065);
        load_then_store(3'b000, 43, 56, 32'hffffff87);
        load_then_store(3'b100, 40, 60, 32'h000000a1);
        load_then_store(3'b001, 40, 64, 32'hfffff0a1);
        load_then_store(3'b101, 42, 68, 32'h00008765);
        load_then_store(3'b001, 42, 72, 32'hffff8765);
        load_then_store(3'b101, 40, 76, 32'h0000f0a1);
        // sub-word stores
        emit(s_type(81, 16, 10, 3'b000));
        emit(s_type(83, 16, 10, 3'b000));
        emit(s_type(86, 16, 10, 3'b001));
        emit(s_type(88, 16, 10, 3'b001));
        expect_store(32'h150, 4'b0010, 32'h65f0a100);
        expect_store(32'h150, 4'b1000, 32'ha1000000);
        expect_store(32'h154, 4'b1100, 32'hf0a10000);
        expect_store(32'h158, 4'b0011, 32'h8765f0a1);
        // x0, lui, auipc
        emit(i_type(123, 0, 3'b000, 0, rv_pkg::op_imm));
        emit(s_type(92, 0, 10, 3'b010));
        expect_store(32'h15c, 4'b1111, 32'h00000000);
        emit(u_type(32'habcde, 18, rv_pkg::op_lui));
        emit(s_type(96, 18, 10, 3'b010));
        expect_store(32'h160, 4'b1111, 32'habcde000);
        auipc_pc = START_PC + 32'(prog_len * 4);
        emit(u_type(1, 19, rv_pkg::op_auipc));
        emit(s_type(100, 19, 10, 3'b010));
        expect_store(32'h164, 4'b1111, auipc_pc + 32'h1000);
    endtask

    // address presented in the cycle that just ended
    always @(posedge clk) begin
        fetch_addr <= imem_addr;
    end

    always @(negedge clk) begin
        logic [31:0] idx;
        idx = (fetch_addr - START_PC) >> 2;
        imem_resp = ($urandom % 4) != 0;
        imem_rdata = (idx < 32'd128) ? prog[idx[6:0]] : NOP;
    end

    // data memory answers 1 to 4 cycles after the request shows up
    always @(negedge clk) begin
        logic [31:0] w;
        if (rst) begin
            dmem_resp = 1'b0;
            in_flight = 1'b0;
            wait_left = 0;
        end else if (dmem_resp) begin
            dmem_resp = 1'b0;
            in_flight = 1'b0;
        end else if (dmem_rmask != 4'b0 || dmem_wmask != 4'b0) begin
            if (!in_flight) begin
                in_flight = 1'b1;
                wait_left = 1 + int'($urandom % 4);
            end else begin
                wait_left--;
                if (wait_left == 0) begin
                    w = read_word(dmem_addr);
                    dmem_rdata = w;
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_wmask[b]) begin
                            w[8*b +: 8] = dmem_wdata[8*b +: 8];
                        end
                    end
                    if (dmem_wmask != 4'b0) begin
                        dmem[dmem_addr] = w;
                    end
                    dmem_resp = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        // reset has taken effect once an earlier edge saw rst high
        if (prev_rst) begin
            assert (imem_addr == START_PC) else begin
                reset_errors++;
                $display("[ERROR] imem_addr got %h expected %h", imem_addr, START_PC);
            end
            assert (dmem_rmask == 4'b0 && dmem_wmask == 4'b0) else begin
                reset_errors++;
                $display("[ERROR] dmem_rmask/dmem_wmask got %h/%h expected 0/0",
                         dmem_rmask, dmem_wmask);
            end
        end
        prev_rst = rst;
        assert (imem_rmask == 4'b1111) else begin
            fetch_errors++;
            $display("[ERROR] imem_rmask got %h expected %h", imem_rmask, 4'b1111);
        end
        if (req_open) begin
            assert (dmem_addr == held_addr && dmem_rmask == held_rmask &&
                    dmem_wmask == held_wmask && dmem_wdata == held_wdata) else begin
                handshake_errors++;
                $display("[ERROR] dmem request changed: addr %h rmask %h wmask %h wdata %h",
                         dmem_addr, dmem_rmask, dmem_wmask, dmem_wdata);
                $display("[ERROR] dmem request held: addr %h rmask %h wmask %h wdata %h",
                         held_addr, held_rmask, held_wmask, held_wdata);
            end
        end
        req_open = !rst && (dmem_rmask != 4'b0 || dmem_wmask != 4'b0) && !dmem_resp;
        held_addr = dmem_addr;
        held_rmask = dmem_rmask;
        held_wmask = dmem_wmask;
        held_wdata = dmem_wdata;
        if (!rst && dmem_resp && dmem_wmask != 4'b0) begin
            if (store_idx < exp_addr.size()) begin
                assert (dmem_addr == exp_addr[store_idx]) else begin
                    store_errors++;
                    $display("[ERROR] dmem_addr got %h expected %h", dmem_addr,
                             exp_addr[store_idx]);
                end
                assert (dmem_wmask == exp_mask[store_idx]) else begin
                    store_errors++;
                    $display("[ERROR] dmem_wmask got %h expected %h", dmem_wmask,
                             exp_mask[store_idx]);
                end
                assert (dmem_wdata == exp_data[store_idx]) else begin
                    store_errors++;
                    $display("[ERROR] dmem_wdata got %h expected %h", dmem_wdata,
                             exp_data[store_idx]);
                end
            end else begin
                store_errors++;
                $display("unexpected extra store to address %h", dmem_addr);
            end
            store_idx++;
        end
    end

    initial begin
        int cycles;
        int total;
        void'($urandom(15528));
        rst = 1'b1;
        imem_rdata = 32'h0;
        imem_resp = 1'b0;
        dmem_rdata = 32'h0;
        dmem_resp = 1'b0;
        store_idx = 0;
        req_open = 1'b0;
        prev_rst = 1'b0;
        build_program();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (store_idx < exp_addr.size() && cycles < 4000) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < exp_addr.size()) begin
            timeout_errors++;
            $display("timeout: only %0d of %0d stores arrived", store_idx, exp_addr.size());
        end
        // trailing no-ops must not store anything
        repeat (40) @(posedge clk);
        total = store_errors + handshake_errors + reset_errors + fetch_errors + timeout_errors;
        $display("errors: store %0d, handshake %0d, reset %0d, fetch %0d, timeout %0d",
                 store_errors, handshake_errors, reset_errors, fetch_errors, timeout_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.f */
design/rv_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_load_store.sv
design/rv_core.sv
bench/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rv_core_tb \
    -f rv_core.f -o rv_core_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    exit 0
fi
exit 1
